//--- hdl/exPkg.sv
package exPkg;

	//////////////////// Multiply/divide timing

	// Busy length after the start edge
	localparam int MUL_CYCLES = 4;
	localparam int DIV_CYCLES = 32;
	// Down counter sized for the longer run
	localparam int MD_CNT_W = $clog2(DIV_CYCLES + 1);

	typedef logic [MD_CNT_W-1:0] mdCnt;

	//////////////////// Encodings

	// Anything outside this list decodes as reserved
	typedef enum logic [4:0] {
		OP_ADD,
		OP_ADDU,
		OP_SUB,
		OP_AND,
		OP_OR,
		OP_XOR,
		OP_SLT,
		OP_SLL,
		OP_ADDI,
		OP_LUI,
		OP_MULT,
		OP_DIVU,
		OP_MFHI,
		OP_MFLO
	} opCode;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_SLL,
		ALU_LUI
	} aluFn;

	// MIPS cause values, 31 for no exception
	typedef enum logic [4:0] {
		EXC_RI = 5'd10,
		EXC_OV = 5'd12,
		EXC_NONE = 5'd31
	} excCode;

	// Operand source seen by the execute stage
	typedef enum logic [1:0] {
		FWD_REG,
		FWD_EX,
		FWD_WB
	} fwdSel;

	//////////////////// Records

	typedef struct packed {
		logic [31:0] pc;
		opCode op;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [15:0] imm;
	} opPkt;

	typedef struct packed {
		logic valid;
		logic [31:0] pc;
		opCode op;
		aluFn fn;
		logic useImm;
		logic regWrite;
		logic isMulDiv;
		logic readHi;
		logic readLo;
		excCode exc;
		logic [4:0] dest;
		logic [31:0] opA;
		logic [31:0] opB;
		logic [31:0] immExt;
		logic [4:0] shamt;
		fwdSel fwdA;
		fwdSel fwdB;
	} issueRec;

	typedef struct packed {
		logic valid;
		logic [31:0] pc;
		logic [4:0] dest;
		logic regWrite;
		logic [31:0] value;
		excCode exc;
	} execRec;

	typedef struct packed {
		logic [31:0] pc;
		logic [4:0] rd;
		logic [31:0] value;
		logic wen;
		excCode exc;
	} commitRec;

endpackage

//--- hdl/aluUnit.sv
`timescale 1ns/1ps

module aluUnit (
	input  logic [31:0] a,
	input  logic [31:0] b,
	input  exPkg::aluFn fn,
	input  logic [4:0]  shamt,
	output logic [31:0] res,
	output logic        ovf
);

	logic [31:0] sum;
	logic [31:0] diff;
	logic ovfAdd;
	logic ovfSub;

	assign sum = a + b;
	assign diff = a - b;

	// Signed overflow
	// Operand signs agree on add, differ on sub, and result sign flips
	assign ovfAdd = (a[31] == b[31]) && (sum[31] != a[31]);
	assign ovfSub = (a[31] != b[31]) && (diff[31] != a[31]);

	always_comb
	begin
		case (fn)
			exPkg::ALU_SUB: res = diff;
			exPkg::ALU_AND: res = a & b;
			exPkg::ALU_OR: res = a | b;
			exPkg::ALU_XOR: res = a ^ b;
			exPkg::ALU_SLT: res = {31'd0, $signed(a) < $signed(b)};
			exPkg::ALU_SLL: res = b << shamt;
			// Immediate already shifted at issue
			exPkg::ALU_LUI: res = b;
			default: res = sum;
		endcase
	end

	// Flag only meaningful for add and sub
	assign ovf = ((fn == exPkg::ALU_ADD) && ovfAdd) || ((fn == exPkg::ALU_SUB) && ovfSub);

endmodule

//--- hdl/mulDivUnit.sv
`timescale 1ns/1ps

module mulDivUnit (
	input  logic        clk,
	input  logic        arstN,
	input  logic        start,
	input  logic        isDiv,
	input  logic [31:0] a,
	input  logic [31:0] b,
	output logic        busy,
	output logic [31:0] hi,
	output logic [31:0] lo
);

	exPkg::mdCnt count;
	logic isDivQ;
	logic lastStep;
	logic signed [63:0] prodFull;
	// Product, or remainder over quotient while dividing
	logic [63:0] acc;
	logic [31:0] divisor;
	logic [32:0] trial;
	logic [32:0] diff;
	logic [63:0] accStep;

	assign prodFull = $signed(a) * $signed(b);

	//////////////////// Restoring divide step

	// Next dividend bit shifted into the partial remainder
	assign trial = {acc[63:32], acc[31]};
	assign diff = trial - {1'b0, divisor};
	// Borrow keeps the old remainder and shifts in a zero
	// Divisor zero never borrows, so HI ends as the dividend and LO all ones
	assign accStep = diff[32] ? {trial[31:0], acc[30:0], 1'b0}
		: {diff[31:0], acc[30:0], 1'b1};

	//////////////////// Control

	assign busy = (count != '0);
	assign lastStep = (count == exPkg::mdCnt'(1));

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			count <= '0;
			isDivQ <= 1'b0;
			hi <= '0;
			lo <= '0;
		end
		else if (start)
		begin
			count <= isDiv ? exPkg::mdCnt'(exPkg::DIV_CYCLES) : exPkg::mdCnt'(exPkg::MUL_CYCLES);
			isDivQ <= isDiv;
		end
		else if (busy)
		begin
			count <= count - 1'b1;
			// HI/LO change only at the end of a run
			if (lastStep)
				{hi, lo} <= isDivQ ? accStep : acc;
		end
	end

	// Working registers
	always_ff @(posedge clk)
	begin
		if (start)
		begin
			divisor <= b;
			acc <= isDiv ? {32'd0, a} : prodFull;
		end
		else if (busy && isDivQ)
			acc <= accStep;
	end

endmodule

//--- hdl/opIntake.sv
`timescale 1ns/1ps

module opIntake (
	input  logic        clk,
	input  logic        arstN,
	input  logic        opReq,
	input  exPkg::opPkt opData,
	output logic        opAck,
	input  logic        take,
	output logic        slotValid,
	output exPkg::opPkt slotOp
);

	logic capture;

	// Only into an empty slot, and only after the previous ack fell
	assign capture = opReq && !opAck && !slotValid;

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			slotValid <= 1'b0;
			opAck <= 1'b0;
		end
		else
		begin
			// Capture and take never coincide, take needs a full slot
			if (capture)
				slotValid <= 1'b1;
			else if (take)
				slotValid <= 1'b0;
			// Ack rises with the capture
			// and is released once the request drops
			if (capture)
				opAck <= 1'b1;
			else if (!opReq)
				opAck <= 1'b0;
		end
	end

	// Slot payload
	always_ff @(posedge clk)
	begin
		if (capture)
			slotOp <= opData;
	end

endmodule

//--- hdl/regFile.sv
`timescale 1ns/1ps

module regFile (
	input  logic        clk,
	input  logic        arstN,
	input  logic [4:0]  rAddrA,
	input  logic [4:0]  rAddrB,
	output logic [31:0] rDataA,
	output logic [31:0] rDataB,
	input  logic        wEn,
	input  logic [4:0]  wAddr,
	input  logic [31:0] wData
);

	logic [31:0] regs [32];
	logic wLive;

	// r0 stays zero, writes to it dropped
	assign wLive = wEn && (wAddr != 5'd0);

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end
		else if (wLive)
			regs[wAddr] <= wData;
	end

	// Write-first reads
	// Same-cycle write is visible to issue
	assign rDataA = (wLive && wAddr == rAddrA) ? wData : regs[rAddrA];
	assign rDataB = (wLive && wAddr == rAddrB) ? wData : regs[rAddrB];

endmodule

//--- hdl/issueStage.sv
`timescale 1ns/1ps

module issueStage (
	input  logic           clk,
	input  logic           arstN,
	input  logic           advance,
	input  logic           slotValid,
	input  exPkg::opPkt    slotOp,
	output logic           take,
	input  logic           mdBusy,
	output logic [4:0]     rAddrA,
	output logic [4:0]     rAddrB,
	input  logic [31:0]    rDataA,
	input  logic [31:0]    rDataB,
	input  exPkg::execRec  execDest,
	output exPkg::issueRec issueOut
);

	exPkg::issueRec issueNext;
	logic needHiLo;
	logic stall;

	// Producer one stage ahead wins over the one two stages ahead
	function automatic exPkg::fwdSel fwdFor(
		input logic [4:0] src,
		input exPkg::issueRec ex,
		input exPkg::execRec wb
	);
		exPkg::fwdSel sel;
		sel = exPkg::FWD_REG;
		if (wb.valid && wb.regWrite && wb.dest != 5'd0 && wb.dest == src)
			sel = exPkg::FWD_WB;
		if (ex.valid && ex.regWrite && ex.dest != 5'd0 && ex.dest == src)
			sel = exPkg::FWD_EX;
		return sel;
	endfunction

	assign rAddrA = slotOp.rs;
	assign rAddrB = slotOp.rt;

	//////////////////// Stall and take

	// HI/LO users wait out the multiply/divide unit
	assign needHiLo = slotOp.op inside {exPkg::OP_MULT, exPkg::OP_DIVU,
		exPkg::OP_MFHI, exPkg::OP_MFLO};
	assign stall = slotValid && needHiLo && mdBusy;
	assign take = advance && slotValid && !stall;

	//////////////////// Decode

	always_comb
	begin
		issueNext = '0;
		// Bubble unless the slot is taken
		issueNext.valid = take;
		issueNext.pc = slotOp.pc;
		issueNext.op = slotOp.op;
		issueNext.fn = exPkg::ALU_ADD;
		issueNext.exc = exPkg::EXC_NONE;
		issueNext.opA = rDataA;
		issueNext.opB = rDataB;
		issueNext.shamt = slotOp.imm[10:6];
		issueNext.fwdA = fwdFor(slotOp.rs, issueOut, execDest);
		issueNext.fwdB = fwdFor(slotOp.rt, issueOut, execDest);
		case (slotOp.op)
			exPkg::OP_ADD, exPkg::OP_ADDU, exPkg::OP_ADDI: issueNext.fn = exPkg::ALU_ADD;
			exPkg::OP_SUB: issueNext.fn = exPkg::ALU_SUB;
			exPkg::OP_AND: issueNext.fn = exPkg::ALU_AND;
			exPkg::OP_OR: issueNext.fn = exPkg::ALU_OR;
			exPkg::OP_XOR: issueNext.fn = exPkg::ALU_XOR;
			exPkg::OP_SLT: issueNext.fn = exPkg::ALU_SLT;
			exPkg::OP_SLL: issueNext.fn = exPkg::ALU_SLL;
			exPkg::OP_LUI: issueNext.fn = exPkg::ALU_LUI;
			exPkg::OP_MULT, exPkg::OP_DIVU: issueNext.isMulDiv = 1'b1;
			exPkg::OP_MFHI: issueNext.readHi = 1'b1;
			exPkg::OP_MFLO: issueNext.readLo = 1'b1;
			default: issueNext.exc = exPkg::EXC_RI;
		endcase
		// I-type ops take the immediate and write rt
		issueNext.useImm = (slotOp.op == exPkg::OP_ADDI) || (slotOp.op == exPkg::OP_LUI);
		issueNext.dest = issueNext.useImm ? slotOp.rt : slotOp.rd;
		// LUI shifts, the rest sign-extend
		if (slotOp.op == exPkg::OP_LUI)
			issueNext.immExt = {slotOp.imm, 16'h0000};
		else
			issueNext.immExt = {{16{slotOp.imm[15]}}, slotOp.imm};
		// Reserved ops and HI/LO writers leave the GPRs alone
		issueNext.regWrite = !issueNext.isMulDiv && (issueNext.exc == exPkg::EXC_NONE);
	end

	//////////////////// Issue register

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
			issueOut <= '0;
		else if (advance)
			issueOut <= issueNext;
	end

endmodule

//--- hdl/execStage.sv
`timescale 1ns/1ps

module execStage (
	input  logic           clk,
	input  logic           arstN,
	input  logic           advance,
	input  exPkg::issueRec issueIn,
	input  logic [31:0]    bypassWb,
	output exPkg::execRec  execOut,
	output logic           mdBusy
);

	logic [31:0] bypassEx;
	logic exLive;
	logic [31:0] srcA;
	logic [31:0] srcB;
	logic [31:0] aluB;
	logic [31:0] aluRes;
	logic aluOvf;
	logic ovfTrap;
	logic mdStart;
	logic mdRun;
	logic [31:0] hi;
	logic [31:0] lo;
	exPkg::excCode exc;
	exPkg::execRec execNext;

	function automatic logic [31:0] pickSrc(
		input exPkg::fwdSel sel,
		input logic [31:0] regVal,
		input logic exOk,
		input logic [31:0] exVal,
		input logic [31:0] wbVal
	);
		logic [31:0] v;
		case (sel)
			// Trapped producer never wrote, so the file value still holds
			exPkg::FWD_EX: v = exOk ? exVal : regVal;
			exPkg::FWD_WB: v = wbVal;
			default: v = regVal;
		endcase
		return v;
	endfunction

	//////////////////// Operands

	assign bypassEx = execOut.value;
	assign exLive = execOut.valid && execOut.regWrite;
	assign srcA = pickSrc(issueIn.fwdA, issueIn.opA, exLive, bypassEx, bypassWb);
	assign srcB = pickSrc(issueIn.fwdB, issueIn.opB, exLive, bypassEx, bypassWb);
	assign aluB = issueIn.useImm ? issueIn.immExt : srcB;

	aluUnit alu (
		.a(srcA),
		.b(aluB),
		.fn(issueIn.fn),
		.shamt(issueIn.shamt),
		.res(aluRes),
		.ovf(aluOvf)
	);

	//////////////////// Multiply/divide

	// Start only on a moving pipeline so a frozen op is not run twice
	assign mdStart = advance && issueIn.valid && issueIn.isMulDiv;
	assign mdBusy = mdStart || mdRun;

	mulDivUnit mulDiv (
		.clk(clk),
		.arstN(arstN),
		.start(mdStart),
		.isDiv(issueIn.op == exPkg::OP_DIVU),
		.a(srcA),
		.b(srcB),
		.busy(mdRun),
		.hi(hi),
		.lo(lo)
	);

	//////////////////// Result and exception

	// ADDU shares the adder but never traps
	assign ovfTrap = aluOvf && (issueIn.op inside {exPkg::OP_ADD, exPkg::OP_SUB, exPkg::OP_ADDI});

	always_comb
	begin
		if (issueIn.exc != exPkg::EXC_NONE)
			exc = issueIn.exc;
		else if (ovfTrap)
			exc = exPkg::EXC_OV;
		else
			exc = exPkg::EXC_NONE;
		execNext.valid = issueIn.valid;
		execNext.pc = issueIn.pc;
		execNext.dest = issueIn.dest;
		execNext.exc = exc;
		// Trap suppresses the write
		execNext.regWrite = issueIn.valid && issueIn.regWrite && (exc == exPkg::EXC_NONE);
		if (issueIn.readHi)
			execNext.value = hi;
		else if (issueIn.readLo)
			execNext.value = lo;
		else
			execNext.value = aluRes;
	end

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
			execOut <= '0;
		else if (advance)
			execOut <= execNext;
	end

endmodule

//--- hdl/commitStage.sv
`timescale 1ns/1ps

module commitStage (
	input  logic            clk,
	input  logic            arstN,
	input  exPkg::execRec   execIn,
	output logic            advance,
	output logic            wEn,
	output logic [4:0]      wAddr,
	output logic [31:0]     wData,
	output logic [31:0]     bypassWb,
	output logic            commitReq,
	input  logic            commitAck,
	output exPkg::commitRec commitData
);

	// Commit register
	exPkg::execRec commitQ;
	logic handshakeDone;

	//////////////////// Shared advance

	// Request dropped and ack already back low
	assign handshakeDone = !commitReq && !commitAck;
	// Empty register or finished handshake frees the whole pipeline
	assign advance = !commitQ.valid || handshakeDone;

	//////////////////// Register file write

	// Same edge that moves the record in
	assign wEn = advance && execIn.valid && execIn.regWrite;
	assign wAddr = execIn.dest;
	assign wData = execIn.value;

	// Held value for operands two stages behind
	assign bypassWb = commitQ.value;

	//////////////////// Commit register and sender

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			commitQ <= '0;
			commitReq <= 1'b0;
		end
		else if (advance)
		begin
			commitQ <= execIn;
			// Bubbles load silently
			commitReq <= execIn.valid;
		end
		else if (commitReq && commitAck)
			commitReq <= 1'b0;
	end

	// Output record, stable while the register holds
	always_comb
	begin
		commitData.pc = commitQ.pc;
		commitData.rd = commitQ.dest;
		commitData.value = commitQ.value;
		commitData.wen = commitQ.regWrite;
		commitData.exc = commitQ.exc;
	end

endmodule

//--- hdl/execBackend.sv
`timescale 1ns/1ps

module execBackend (
	input  logic            clk,
	input  logic            arstN,
	input  logic            opReq,
	output logic            opAck,
	input  exPkg::opPkt     opData,
	output logic            commitReq,
	input  logic            commitAck,
	output exPkg::commitRec commitData
);

	logic slotValid;
	exPkg::opPkt slotOp;
	logic take;
	logic advance;
	logic mdBusy;
	logic [4:0] rAddrA;
	logic [4:0] rAddrB;
	logic [31:0] rDataA;
	logic [31:0] rDataB;
	logic wEn;
	logic [4:0] wAddr;
	logic [31:0] wData;
	logic [31:0] bypassWb;
	exPkg::issueRec issueQ;
	exPkg::execRec execQ;

	opIntake intake (
		.clk(clk),
		.arstN(arstN),
		.opReq(opReq),
		.opData(opData),
		.opAck(opAck),
		.take(take),
		.slotValid(slotValid),
		.slotOp(slotOp)
	);

	regFile gpr (
		.clk(clk),
		.arstN(arstN),
		.rAddrA(rAddrA),
		.rAddrB(rAddrB),
		.rDataA(rDataA),
		.rDataB(rDataB),
		.wEn(wEn),
		.wAddr(wAddr),
		.wData(wData)
	);

	// Issue register feeds execute, execute register feeds commit
	issueStage issue (
		.clk(clk),
		.arstN(arstN),
		.advance(advance),
		.slotValid(slotValid),
		.slotOp(slotOp),
		.take(take),
		.mdBusy(mdBusy),
		.rAddrA(rAddrA),
		.rAddrB(rAddrB),
		.rDataA(rDataA),
		.rDataB(rDataB),
		.execDest(execQ),
		.issueOut(issueQ)
	);

	execStage exec (
		.clk(clk),
		.arstN(arstN),
		.advance(advance),
		.issueIn(issueQ),
		.bypassWb(bypassWb),
		.execOut(execQ),
		.mdBusy(mdBusy)
	);

	// Shared advance comes from the output handshake
	commitStage commit (
		.clk(clk),
		.arstN(arstN),
		.execIn(execQ),
		.advance(advance),
		.wEn(wEn),
		.wAddr(wAddr),
		.wData(wData),
		.bypassWb(bypassWb),
		.commitReq(commitReq),
		.commitAck(commitAck),
		.commitData(commitData)
	);

endmodule

//--- dv/execBackendTb.sv
`timescale 1ns/1ps

module execBackendTb;

	localparam int NUM_OPS = 400;
	// Worst case per op is a divide plus handshake slack
	localparam int TIMEOUT_CYCLES = NUM_OPS * (exPkg::DIV_CYCLES + 16);
	localparam logic [31:0] SEED = 32'h0593e72d;

	logic clk;
	logic arstN;
	logic opReq;
	logic opAck;
	exPkg::opPkt opData;
	logic commitReq;
	logic commitAck;
	exPkg::commitRec commitData;

	logic [31:0] lfsrState;
	logic [31:0] modelGpr [32];
	logic [31:0] modelHi;
	logic [31:0] modelLo;
	int hiLoNext;
	int received;
	int cycles;
	exPkg::commitRec expQ [$];

	execBackend uut (
		.clk(clk),
		.arstN(arstN),
		.opReq(opReq),
		.opAck(opAck),
		.opData(opData),
		.commitReq(commitReq),
		.commitAck(commitAck),
		.commitData(commitData)
	);

	//////////////////// Random source

	// Galois LFSR, one step per bit
	function automatic logic [31:0] takeBits(input int n);
		logic [31:0] val;
		val = '0;
		for (int i = 0; i < n; i++)
		begin
			val = {val[30:0], lfsrState[0]};
			lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 32'h80200003) : (lfsrState >> 1);
		end
		return val;
	endfunction

	//////////////////// Reporting

	task automatic stopFail(input string line);
		$display("%s", line);
		$display(">>> FAIL");
		$fatal(1, "stopped at first error");
	endtask

	task automatic checkLevel(input logic got, input logic exp, input string name);
		if (got !== exp)
			stopFail($sformatf("[FAIL] %0t: %s is %b, expected %b", $time, name, got, exp));
	endtask

	// Value only matters when the record writes
	task automatic checkCommit(input exPkg::commitRec got, input exPkg::commitRec exp);
		if (got.pc !== exp.pc || got.rd !== exp.rd || got.wen !== exp.wen
			|| got.exc !== exp.exc || (exp.wen && got.value !== exp.value))
			stopFail($sformatf(
				"[FAIL] %0t: pc %h got rd %0d val %h wen %b exc %0d, exp rd %0d val %h wen %b exc %0d",
				$time, got.pc, got.rd, got.value, got.wen, got.exc,
				exp.rd, exp.value, exp.wen, exp.exc));
	endtask

	//////////////////// Stimulus and ISA model

	task automatic makeOp(input int idx, output exPkg::opPkt pkt);
		logic [3:0] sel;
		pkt.pc = 32'h0040_0000 + 32'(idx * 4);
		// Only r0..r7 so hazards are frequent
		pkt.rs = 5'(takeBits(3));
		pkt.rt = 5'(takeBits(3));
		pkt.rd = 5'(takeBits(3));
		pkt.imm = 16'(takeBits(16));
		if (idx < 8)
		begin
			// LUI then ADDI into r1..r4
			pkt.rt = 5'(idx / 2 + 1);
			pkt.rs = pkt.rt;
			pkt.op = (idx % 2 == 0) ? exPkg::OP_LUI : exPkg::OP_ADDI;
		end
		else if (hiLoNext != 0)
		begin
			pkt.op = (hiLoNext == 2) ? exPkg::OP_MFHI : exPkg::OP_MFLO;
			hiLoNext--;
		end
		else
		begin
			sel = 4'(takeBits(4));
			case (sel)
				4'd0: pkt.op = exPkg::OP_ADD;
				4'd1: pkt.op = exPkg::OP_ADDU;
				4'd2: pkt.op = exPkg::OP_SUB;
				4'd3: pkt.op = exPkg::OP_AND;
				4'd4: pkt.op = exPkg::OP_OR;
				4'd5: pkt.op = exPkg::OP_XOR;
				4'd6: pkt.op = exPkg::OP_SLT;
				4'd7: pkt.op = exPkg::OP_SLL;
				4'd8, 4'd9: pkt.op = exPkg::OP_ADDI;
				4'd10: pkt.op = exPkg::OP_LUI;
				4'd11: pkt.op = exPkg::OP_MULT;
				4'd12: pkt.op = exPkg::OP_DIVU;
				4'd13: pkt.op = exPkg::OP_MFHI;
				4'd14: pkt.op = exPkg::OP_MFLO;
				// Reserved encodings 14..29
				default: pkt.op = exPkg::opCode'(5'd14 + 5'(takeBits(4)));
			endcase
			if (pkt.op == exPkg::OP_MULT || pkt.op == exPkg::OP_DIVU)
				hiLoNext = 2;
		end
	endtask

	task automatic modelOp(input exPkg::opPkt p, output exPkg::commitRec e);
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] immExt;
		logic [32:0] wide;
		logic [63:0] prod;
		a = modelGpr[p.rs];
		b = modelGpr[p.rt];
		immExt = {{16{p.imm[15]}}, p.imm};
		wide = '0;
		e.pc = p.pc;
		e.rd = (p.op == exPkg::OP_ADDI || p.op == exPkg::OP_LUI) ? p.rt : p.rd;
		e.exc = exPkg::EXC_NONE;
		e.wen = 1'b1;
		e.value = '0;
		case (p.op)
			exPkg::OP_ADD: wide = {a[31], a} + {b[31], b};
			exPkg::OP_SUB: wide = {a[31], a} - {b[31], b};
			exPkg::OP_ADDI: wide = {a[31], a} + {immExt[31], immExt};
			exPkg::OP_ADDU: e.value = a + b;
			exPkg::OP_AND: e.value = a & b;
			exPkg::OP_OR: e.value = a | b;
			exPkg::OP_XOR: e.value = a ^ b;
			exPkg::OP_SLT: e.value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			exPkg::OP_SLL: e.value = b << p.imm[10:6];
			exPkg::OP_LUI: e.value = {p.imm, 16'h0000};
			exPkg::OP_MFHI: e.value = modelHi;
			exPkg::OP_MFLO: e.value = modelLo;
			exPkg::OP_MULT:
			begin
				// Low 64 bits of sign-extended operands give the signed product
				prod = {{32{a[31]}}, a} * {{32{b[31]}}, b};
				{modelHi, modelLo} = prod;
				e.wen = 1'b0;
			end
			exPkg::OP_DIVU:
			begin
				if (b == 32'd0)
				begin
					modelHi = a;
					modelLo = '1;
				end
				else
				begin
					modelHi = a % b;
					modelLo = a / b;
				end
				e.wen = 1'b0;
			end
			default: e.exc = exPkg::EXC_RI;
		endcase
		// Signed adds trap when the two top bits of the wide sum differ
		if (p.op inside {exPkg::OP_ADD, exPkg::OP_SUB, exPkg::OP_ADDI})
		begin
			e.value = wide[31:0];
			if (wide[32] != wide[31])
				e.exc = exPkg::EXC_OV;
		end
		if (e.exc != exPkg::EXC_NONE)
			e.wen = 1'b0;
		if (e.wen && e.rd != 5'd0)
			modelGpr[e.rd] = e.value;
	endtask

	//////////////////// Clock and timeout

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	initial
	begin
		cycles = 0;
		forever
		begin
			@(posedge clk);
			cycles++;
			if (cycles >= TIMEOUT_CYCLES)
				stopFail($sformatf("Run hung: only %0d of %0d records committed in %0d cycles",
					received, NUM_OPS, cycles));
		end
	end

	//////////////////// Input side driver

	initial
	begin
		exPkg::opPkt pkt;
		exPkg::commitRec exp;
		int gap;
		lfsrState = SEED;
		hiLoNext = 0;
		received = 0;
		modelHi = '0;
		modelLo = '0;
		for (int i = 0; i < 32; i++)
			modelGpr[i] = '0;
		arstN = 1'b0;
		opReq = 1'b0;
		opData = '0;
		commitAck = 1'b0;
		repeat (8) @(posedge clk);
		arstN <= 1'b1;
		// Both ports idle out of reset
		repeat (2)
		begin
			@(negedge clk);
			checkLevel(opAck, 1'b0, "opAck after reset");
			checkLevel(commitReq, 1'b0, "commitReq after reset");
		end
		for (int i = 0; i < NUM_OPS; i++)
		begin
			@(posedge clk);
			makeOp(i, pkt);
			modelOp(pkt, exp);
			expQ.push_back(exp);
			opReq <= 1'b1;
			opData <= pkt;
			do @(negedge clk); while (!opAck);
			@(posedge clk);
			opReq <= 1'b0;
			do @(negedge clk); while (opAck);
			@(posedge clk);
			gap = int'(takeBits(2));
			repeat (gap) @(posedge clk);
		end
		while (received < NUM_OPS)
			@(negedge clk);
		// Window for stray extra records
		repeat (6) @(negedge clk);
		$display(">>> PASS");
		$finish;
	end

	//////////////////// Output side receiver

	initial
	begin
		int delay;
		wait (arstN);
		forever
		begin
			@(negedge clk);
			if (commitReq)
			begin
				if (expQ.size() == 0)
					stopFail("Commit record arrived when none was expected");
				checkCommit(commitData, expQ.pop_front());
				received++;
				// Slow ack to back up the pipeline
				delay = int'(takeBits(2));
				repeat (delay) @(posedge clk);
				@(posedge clk);
				commitAck <= 1'b1;
				do @(negedge clk); while (commitReq);
				@(posedge clk);
				commitAck <= 1'b0;
			end
		end
	end

	//////////////////// Four-phase monitor

	initial
	begin
		logic prevOpReq;
		logic prevOpAck;
		logic prevReq;
		logic prevAck;
		exPkg::commitRec prevData;
		wait (arstN);
		@(negedge clk);
		prevOpReq = opReq;
		prevOpAck = opAck;
		prevReq = commitReq;
		prevAck = commitAck;
		prevData = commitData;
		forever
		begin
			@(negedge clk);
			if (opAck && !prevOpAck && !prevOpReq)
				stopFail("Input port raised opAck without a pending opReq");
			if (!opAck && prevOpAck && prevOpReq)
				stopFail("Input port dropped opAck while opReq was still high");
			if (commitReq && !prevReq && prevAck)
				stopFail("Output port raised commitReq before commitAck fell");
			if (!commitReq && prevReq && !prevAck)
				stopFail("Output port dropped commitReq without commitAck");
			if (commitReq && prevReq && commitData !== prevData)
				stopFail("commitData changed while commitReq was high");
			prevOpReq = opReq;
			prevOpAck = opAck;
			prevReq = commitReq;
			prevAck = commitAck;
			prevData = commitData;
		end
	end

endmodule

//--- vlog.f
hdl/exPkg.sv
hdl/aluUnit.sv
hdl/mulDivUnit.sv
hdl/opIntake.sv
hdl/regFile.sv
hdl/issueStage.sv
hdl/execStage.sv
hdl/commitStage.sv
hdl/execBackend.sv
dv/execBackendTb.sv

//--- Makefile
TOP = execBackendTb

.PHONY: sim clean

sim:
	verilator --binary --timing -f vlog.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qx '>>> PASS'

clean:
	rm -rf obj_dir
